// ==== hdl/soc_periph_pkg.sv ====
// Shared APB types, address map, register indices and reset constants
// for the peripheral subsystem. Every RTL module imports it by wildcard.

package soc_periph_pkg;

    localparam int APB_ADDR_W = 32;
    localparam int APB_DATA_W = 32;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    typedef struct packed {
        apb_addr_t paddr;
        apb_data_t pwdata;
        logic      pwrite;
        logic      psel;
        logic      penable;
    } apb_req_t;                           // master to slave, 67 bits

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;                           // slave to master, 34 bits

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////
    localparam int PERIPH_SEL_LSB = 8;     // paddr[11:8] picks the slave
    localparam int PERIPH_SEL_W   = 4;
    localparam int REG_IDX_LSB    = 2;     // paddr[7:2] picks the register
    localparam int REG_IDX_W      = 6;

    localparam logic [PERIPH_SEL_W-1:0] GPIO_BASE_IDX = 4'd0;
    localparam logic [PERIPH_SEL_W-1:0] CTRL_BASE_IDX = 4'd1;
    localparam logic [PERIPH_SEL_W-1:0] EVT_BASE_IDX  = 4'd2;

    typedef enum logic [1:0] {
        SEL_GPIO,
        SEL_CTRL,
        SEL_EVT,
        SEL_NONE
    } periph_sel_e;

    typedef enum logic [REG_IDX_W-1:0] {
        GPIO_DIR        = 6'd0,
        GPIO_OUT        = 6'd1,
        GPIO_IN         = 6'd2,
        GPIO_INT_EN     = 6'd3,
        GPIO_INT_STATUS = 6'd4
    } gpio_reg_e;

    typedef enum logic [REG_IDX_W-1:0] {
        CTRL_BOOTADDR = 6'd0,
        CTRL_FETCHEN  = 6'd1,
        CTRL_INFO     = 6'd2
    } ctrl_reg_e;

    typedef enum logic [REG_IDX_W-1:0] {
        EVT_SW      = 6'd0,
        EVT_REF_CNT = 6'd1
    } evt_reg_e;

    localparam apb_data_t BOOT_ADDR_RST = 32'h1A00_0080;
    localparam apb_data_t SOC_INFO_ID   = 32'h0001_0003;

    // fabric controller event vector
    localparam int FC_EVT_W         = 32;
    typedef logic [FC_EVT_W-1:0] fc_events_t;
    localparam int SW_EVT_W         = 8;   // bits 7:0
    localparam int REF_EDGE_EVT_BIT = 14;
    localparam int GPIO_EVT_BIT     = 15;
    localparam int REF_CNT_W        = 16;

endpackage

// ==== hdl/apb_periph_decoder.sv ====
// APB address decoder. Picks one slave from paddr[11:8], forwards the
// request with psel gated, and muxes the selected response back.
// Addresses outside the map complete with pslverr and zero data.
`timescale 1ns/100ps

module apb_periph_decoder
    import soc_periph_pkg::*;
(
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,

    output apb_req_t gpio_req_o,
    output apb_req_t ctrl_req_o,
    output apb_req_t evt_req_o,

    input  apb_rsp_t gpio_rsp_i,
    input  apb_rsp_t ctrl_rsp_i,
    input  apb_rsp_t evt_rsp_i
);

    periph_sel_e sel;
    logic        access;                   // second cycle of a transfer

    assign access = apb_req_i.psel & apb_req_i.penable;

    always_comb begin
        case (apb_req_i.paddr[PERIPH_SEL_LSB +: PERIPH_SEL_W])
            GPIO_BASE_IDX: sel = SEL_GPIO;
            CTRL_BASE_IDX: sel = SEL_CTRL;
            EVT_BASE_IDX:  sel = SEL_EVT;
            default:       sel = SEL_NONE;
        endcase
    end

    // same fields to all slaves, only one sees psel
    always_comb begin
        gpio_req_o      = apb_req_i;
        ctrl_req_o      = apb_req_i;
        evt_req_o       = apb_req_i;
        gpio_req_o.psel = apb_req_i.psel & (sel == SEL_GPIO);
        ctrl_req_o.psel = apb_req_i.psel & (sel == SEL_CTRL);
        evt_req_o.psel  = apb_req_i.psel & (sel == SEL_EVT);
    end

    always_comb begin
        case (sel)
            SEL_GPIO: apb_rsp_o = gpio_rsp_i;
            SEL_CTRL: apb_rsp_o = ctrl_rsp_i;
            SEL_EVT:  apb_rsp_o = evt_rsp_i;
            default: begin
                apb_rsp_o.prdata  = '0;
                apb_rsp_o.pready  = access;
                apb_rsp_o.pslverr = access;  // unmapped, no side effect
            end
        endcase
    end

endmodule

// ==== hdl/soc_ctrl_regs.sv ====
// SoC control slave. Holds the fabric controller boot address and fetch
// enable, both writable over APB, plus a read-only info word.
`timescale 1ns/100ps

module soc_ctrl_regs
    import soc_periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  apb_req_t  apb_req_i,
    output apb_rsp_t  apb_rsp_o,
    output apb_data_t fc_bootaddr_o,
    output logic      fc_fetchen_o
);

    ctrl_reg_e reg_idx;
    logic      wr_en;
    logic      rd_en;
    apb_data_t rdata;
    apb_data_t bootaddr_q;
    logic      fetchen_q;

    assign reg_idx = ctrl_reg_e'(apb_req_i.paddr[REG_IDX_LSB +: REG_IDX_W]);
    assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
    assign rd_en   = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bootaddr_q <= BOOT_ADDR_RST;
            fetchen_q  <= 1'b0;
        end else if (wr_en) begin
            case (reg_idx)
                CTRL_BOOTADDR: bootaddr_q <= apb_req_i.pwdata;
                CTRL_FETCHEN:  fetchen_q  <= apb_req_i.pwdata[0];
                default:       ;             // info is read only
            endcase
        end
    end

    always_comb begin
        case (reg_idx)
            CTRL_BOOTADDR: rdata = bootaddr_q;
            CTRL_FETCHEN:  rdata = {{(APB_DATA_W-1){1'b0}}, fetchen_q};
            CTRL_INFO:     rdata = SOC_INFO_ID;
            default:       rdata = '0;
        endcase
    end

    assign apb_rsp_o.prdata  = rd_en ? rdata : '0;
    assign apb_rsp_o.pready  = apb_req_i.psel & apb_req_i.penable;
    assign apb_rsp_o.pslverr = 1'b0;

    assign fc_bootaddr_o = bootaddr_q;
    assign fc_fetchen_o  = fetchen_q;

endmodule

// ==== hdl/gpio_ctrl.sv ====
// GPIO slave with direction and output registers, a two-flop input
// synchronizer and a per-pin rising edge interrupt. The interrupt status
// is sticky and clears when software reads it.
`timescale 1ns/100ps

module gpio_ctrl
    import soc_periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  apb_req_t  apb_req_i,
    output apb_rsp_t  apb_rsp_o,
    input  apb_data_t gpio_in_i,
    output apb_data_t gpio_out_o,
    output apb_data_t gpio_dir_o,
    output logic      gpio_irq_o
);

    gpio_reg_e reg_idx;
    logic      wr_en;
    logic      rd_en;
    logic      status_clr;
    apb_data_t rdata;

    apb_data_t dir_q;
    apb_data_t out_q;
    apb_data_t int_en_q;
    apb_data_t status_q;
    logic      irq_q;

    apb_data_t in_sync1_q;
    apb_data_t in_sync2_q;                 // what GPIO_IN returns
    apb_data_t in_sync3_q;                 // previous value for edge detect
    apb_data_t rise;

    assign reg_idx    = gpio_reg_e'(apb_req_i.paddr[REG_IDX_LSB +: REG_IDX_W]);
    assign wr_en      = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
    assign rd_en      = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;
    assign status_clr = rd_en & (reg_idx == GPIO_INT_STATUS);

    ////////////////////////////////////////////////////////////
    // input sync and edge detect
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            in_sync1_q <= '0;
            in_sync2_q <= '0;
            in_sync3_q <= '0;
        end else begin
            in_sync1_q <= gpio_in_i;
            in_sync2_q <= in_sync1_q;
            in_sync3_q <= in_sync2_q;
        end
    end

    assign rise = in_sync2_q & ~in_sync3_q & int_en_q;  // enabled pins only

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            int_en_q <= '0;
            status_q <= '0;
            irq_q    <= 1'b0;
        end else begin
            if (wr_en) begin
                case (reg_idx)
                    GPIO_DIR:    dir_q    <= apb_req_i.pwdata;
                    GPIO_OUT:    out_q    <= apb_req_i.pwdata;
                    GPIO_INT_EN: int_en_q <= apb_req_i.pwdata;
                    default:     ;
                endcase
            end
            status_q <= (status_clr ? '0 : status_q) | rise;  // new edge beats clear
            irq_q    <= |rise;
        end
    end

    always_comb begin
        case (reg_idx)
            GPIO_DIR:        rdata = dir_q;
            GPIO_OUT:        rdata = out_q;
            GPIO_IN:         rdata = in_sync2_q;
            GPIO_INT_EN:     rdata = int_en_q;
            GPIO_INT_STATUS: rdata = status_q;
            default:         rdata = '0;
        endcase
    end

    assign apb_rsp_o.prdata  = rd_en ? rdata : '0;
    assign apb_rsp_o.pready  = apb_req_i.psel & apb_req_i.penable;
    assign apb_rsp_o.pslverr = 1'b0;

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign gpio_irq_o = irq_q;

endmodule

// ==== hdl/fc_event_map.sv ====
// Fabric controller event mapper. Turns software writes, slow clock
// edges and the GPIO interrupt into one-cycle pulses on fc_events_o,
// and counts slow clock edges for software to read.
`timescale 1ns/100ps

module fc_event_map
    import soc_periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  apb_req_t   apb_req_i,
    output apb_rsp_t   apb_rsp_o,
    input  logic       slow_clk_i,
    input  logic       gpio_irq_i,
    output fc_events_t fc_events_o
);

    evt_reg_e               reg_idx;
    logic                   wr_en;
    logic                   rd_en;
    logic                   sw_wr;
    apb_data_t              rdata;

    logic [2:0]             ref_sync_q;    // [1] is stable, [2] is last
    logic                   ref_edge;
    logic [REF_CNT_W-1:0]   ref_cnt_q;
    fc_events_t             events_d;
    fc_events_t             events_q;

    assign reg_idx = evt_reg_e'(apb_req_i.paddr[REG_IDX_LSB +: REG_IDX_W]);
    assign wr_en   = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
    assign rd_en   = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;
    assign sw_wr   = wr_en & (reg_idx == EVT_SW);

    assign ref_edge = ref_sync_q[1] ^ ref_sync_q[2];  // rise or fall

    always_comb begin
        events_d                   = '0;
        events_d[SW_EVT_W-1:0]     = sw_wr ? apb_req_i.pwdata[SW_EVT_W-1:0] : '0;
        events_d[REF_EDGE_EVT_BIT] = ref_edge;
        events_d[GPIO_EVT_BIT]     = gpio_irq_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ref_sync_q <= '0;
            ref_cnt_q  <= '0;
            events_q   <= '0;
        end else begin
            ref_sync_q <= {ref_sync_q[1:0], slow_clk_i};
            events_q   <= events_d;
            if (ref_edge) begin
                ref_cnt_q <= ref_cnt_q + 1'b1;     // wraps
            end
        end
    end

    always_comb begin
        case (reg_idx)
            EVT_REF_CNT: rdata = {{(APB_DATA_W-REF_CNT_W){1'b0}}, ref_cnt_q};
            default:     rdata = '0;            // EVT_SW is write only
        endcase
    end

    assign apb_rsp_o.prdata  = rd_en ? rdata : '0;
    assign apb_rsp_o.pready  = apb_req_i.psel & apb_req_i.penable;
    assign apb_rsp_o.pslverr = 1'b0;

    assign fc_events_o = events_q;

endmodule

// ==== hdl/soc_peripherals.sv ====
// Peripheral subsystem top. One APB slave port feeds the decoder, which
// fans out to SoC control, GPIO and the fabric controller event mapper.
`timescale 1ns/100ps

module soc_peripherals
    import soc_periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  apb_req_t   apb_req_i,
    output apb_rsp_t   apb_rsp_o,
    input  apb_data_t  gpio_in_i,
    output apb_data_t  gpio_out_o,
    output apb_data_t  gpio_dir_o,
    input  logic       slow_clk_i,
    output apb_data_t  fc_bootaddr_o,
    output logic       fc_fetchen_o,
    output fc_events_t fc_events_o
);

    apb_req_t gpio_req;
    apb_req_t ctrl_req;
    apb_req_t evt_req;
    apb_rsp_t gpio_rsp;
    apb_rsp_t ctrl_rsp;
    apb_rsp_t evt_rsp;
    logic     gpio_irq;                    // rising edge pulse to mapper

    ////////////////////////////////////////////////////////////
    // bus decode
    ////////////////////////////////////////////////////////////
    apb_periph_decoder i_decoder (
        .apb_req_i  ( apb_req_i ),
        .apb_rsp_o  ( apb_rsp_o ),
        .gpio_req_o ( gpio_req  ),
        .ctrl_req_o ( ctrl_req  ),
        .evt_req_o  ( evt_req   ),
        .gpio_rsp_i ( gpio_rsp  ),
        .ctrl_rsp_i ( ctrl_rsp  ),
        .evt_rsp_i  ( evt_rsp   )
    );

    ////////////////////////////////////////////////////////////
    // slaves
    ////////////////////////////////////////////////////////////
    soc_ctrl_regs i_soc_ctrl (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .apb_req_i     ( ctrl_req      ),
        .apb_rsp_o     ( ctrl_rsp      ),
        .fc_bootaddr_o ( fc_bootaddr_o ),
        .fc_fetchen_o  ( fc_fetchen_o  )
    );

    gpio_ctrl i_gpio (
        .clk_i      ( clk_i      ),
        .rst_n_i    ( rst_n_i    ),
        .apb_req_i  ( gpio_req   ),
        .apb_rsp_o  ( gpio_rsp   ),
        .gpio_in_i  ( gpio_in_i  ),
        .gpio_out_o ( gpio_out_o ),
        .gpio_dir_o ( gpio_dir_o ),
        .gpio_irq_o ( gpio_irq   )
    );

    fc_event_map i_evt_map (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .apb_req_i   ( evt_req     ),
        .apb_rsp_o   ( evt_rsp     ),
        .slow_clk_i  ( slow_clk_i  ),
        .gpio_irq_i  ( gpio_irq    ),
        .fc_events_o ( fc_events_o )
    );

endmodule

// ==== sim/soc_periph_asserts.sv ====
// Concurrent checks on the APB response and the event vector.
// Bound into soc_peripherals at the end of the file, fail_count tallies failed checks.
`timescale 1ns/100ps

module soc_periph_asserts
    import soc_periph_pkg::*;
(
    input logic       clk_i,
    input logic       rst_n_i,
    input apb_req_t   apb_req_i,
    input apb_rsp_t   apb_rsp_i,
    input fc_events_t fc_events_i
);

    int unsigned fail_count = 0;

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        apb_rsp_i.pready |-> (apb_req_i.psel && apb_req_i.penable))
        else begin
            fail_count++;
            $error("pready high outside an access phase");
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        |fc_events_i[SW_EVT_W-1:0] |=> fc_events_i[SW_EVT_W-1:0] == '0)
        else begin
            fail_count++;
            $error("software event held longer than one cycle");
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fc_events_i[REF_EDGE_EVT_BIT] |=> !fc_events_i[REF_EDGE_EVT_BIT])
        else begin
            fail_count++;
            $error("reference clock event held longer than one cycle");
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fc_events_i[GPIO_EVT_BIT] |=> !fc_events_i[GPIO_EVT_BIT])
        else begin
            fail_count++;
            $error("gpio event held longer than one cycle");
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        apb_rsp_i.pslverr |-> apb_rsp_i.pready)
        else begin
            fail_count++;
            $error("pslverr without pready");
        end

endmodule

bind soc_peripherals soc_periph_asserts u_asserts (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .apb_req_i   ( apb_req_i   ),
    .apb_rsp_i   ( apb_rsp_o   ),
    .fc_events_i ( fc_events_o )
);

// ==== sim/tb_soc_peripherals.sv ====
// Directed testbench for the peripheral subsystem. Drives the APB port and
// the pins, checks register outputs, read data and event pulses against
// the register map, and prints one line per test plus a summary.
`timescale 1ns/100ps

module tb_soc_peripherals
    import soc_periph_pkg::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int NUM_TESTS     = 6;
    localparam int READY_TIMEOUT = 16;      // cycles to wait for pready
    localparam int REF_TOGGLES   = 6;

    logic       clk = 1'b0;
    logic       rst_n;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    apb_data_t  gpio_in;
    apb_data_t  gpio_out;
    apb_data_t  gpio_dir;
    logic       slow_clk;
    apb_data_t  fc_bootaddr;
    logic       fc_fetchen;
    fc_events_t fc_events;

    int          errors       = 0;
    int          tests_failed = 0;
    string       cur_test     = "none";
    logic [31:0] lcg_state    = 32'he413_00c3;

    always #(CLK_PERIOD/2) clk = ~clk;

    soc_peripherals dut (
        .clk_i         ( clk         ),
        .rst_n_i       ( rst_n       ),
        .apb_req_i     ( apb_req     ),
        .apb_rsp_o     ( apb_rsp     ),
        .gpio_in_i     ( gpio_in     ),
        .gpio_out_o    ( gpio_out    ),
        .gpio_dir_o    ( gpio_dir    ),
        .slow_clk_i    ( slow_clk    ),
        .fc_bootaddr_o ( fc_bootaddr ),
        .fc_fetchen_o  ( fc_fetchen  ),
        .fc_events_o   ( fc_events   )
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic apb_addr_t reg_addr(input logic [3:0] base, input logic [5:0] idx);
        apb_addr_t addr;
        addr = '0;
        addr[PERIPH_SEL_LSB +: 4] = base;
        addr[REG_IDX_LSB +: 6]    = idx;
        return addr;
    endfunction

    // one setup cycle, then access until pready
    task automatic transfer(input apb_addr_t addr, input apb_data_t wdata, input logic write,
                            output apb_data_t rdata, output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        #1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        apb_req.pwrite  = write;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        #1;                                 // sample mid cycle
        while (!apb_rsp.pready && waits < READY_TIMEOUT) begin
            @(posedge clk);
            #2;
            waits++;
        end
        if (!apb_rsp.pready) begin
            $display("ERROR %s: no pready for address %h", cur_test, addr);
            errors++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);                     // access edge
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
        apb_data_t rdata;
        logic      err;
        transfer(addr, wdata, 1'b1, rdata, err);
        if (err) begin
            $display("ERROR %s: write to %h got an error response", cur_test, addr);
            errors++;
        end
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
        transfer(addr, '0, 1'b0, rdata, err);
    endtask

    task automatic check_data(input string what, input apb_data_t exp, input apb_data_t act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_events(input string what, input fc_events_t exp, input fc_events_t act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_err(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s %s: expected %b, actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // samples once per cycle, mid cycle
    task automatic watch_event_bit(input int bit_idx, input int cycles,
                                   output int pulses, output int first_cycle);
        pulses      = 0;
        first_cycle = -1;
        for (int k = 1; k <= cycles; k++) begin
            @(posedge clk);
            #2;
            if (fc_events[bit_idx]) begin
                pulses++;
                if (first_cycle < 0) begin
                    first_cycle = k;
                end
            end
        end
    endtask

    task automatic report_result(input int errs_before);
        if (errors == errs_before) begin
            $display("%-12s pass", cur_test);
        end else begin
            $display("%-12s fail, %0d errors", cur_test, errors - errs_before);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////
    task automatic reset_values();
        int        errs0;
        apb_data_t rdata;
        logic      err;
        errs0    = errors;
        cur_test = "reset";
        check_data("bootaddr", BOOT_ADDR_RST, fc_bootaddr);
        check_data("fetchen", '0, {31'b0, fc_fetchen});
        check_data("gpio_dir", '0, gpio_dir);
        check_data("gpio_out", '0, gpio_out);
        check_events("events", '0, fc_events);
        apb_read(reg_addr(CTRL_BASE_IDX, CTRL_INFO), rdata, err);
        check_data("info", SOC_INFO_ID, rdata);
        check_err("info err", 1'b0, err);
        report_result(errs0);
    endtask

    task automatic soc_ctrl_rw();
        int        errs0;
        apb_data_t boot;
        apb_data_t fe_word;
        apb_data_t rdata;
        logic      err;
        errs0    = errors;
        cur_test = "soc_ctrl";
        boot     = next_random();
        fe_word  = next_random() | 32'h1;   // upper bits must be ignored
        apb_write(reg_addr(CTRL_BASE_IDX, CTRL_BOOTADDR), boot);
        check_data("bootaddr pin", boot, fc_bootaddr);
        apb_write(reg_addr(CTRL_BASE_IDX, CTRL_FETCHEN), fe_word);
        check_data("fetchen pin", {31'b0, fe_word[0]}, {31'b0, fc_fetchen});
        apb_read(reg_addr(CTRL_BASE_IDX, CTRL_BOOTADDR), rdata, err);
        check_data("bootaddr read", boot, rdata);
        apb_read(reg_addr(CTRL_BASE_IDX, CTRL_FETCHEN), rdata, err);
        check_data("fetchen read", {31'b0, fe_word[0]}, rdata);
        report_result(errs0);
    endtask

    task automatic gpio_pins();
        int        errs0;
        apb_data_t dir;
        apb_data_t out;
        apb_data_t pins;
        apb_data_t rdata;
        logic      err;
        errs0    = errors;
        cur_test = "gpio_pins";
        dir      = next_random();
        out      = next_random();
        pins     = next_random();
        apb_write(reg_addr(GPIO_BASE_IDX, GPIO_DIR), dir);
        check_data("dir pin", dir, gpio_dir);
        apb_write(reg_addr(GPIO_BASE_IDX, GPIO_OUT), out);
        check_data("out pin", out, gpio_out);
        gpio_in = pins;
        repeat (3) @(posedge clk);          // through the synchronizer
        apb_read(reg_addr(GPIO_BASE_IDX, GPIO_IN), rdata, err);
        check_data("gpio_in read", pins, rdata);
        apb_read(reg_addr(4'hA, 6'd0), rdata, err);
        check_err("unmapped err", 1'b1, err);
        check_data("unmapped data", '0, rdata);
        report_result(errs0);
    endtask

    task automatic gpio_interrupt();
        int        errs0;
        apb_data_t mask;
        apb_data_t pins;
        apb_data_t rdata;
        logic      err;
        int        pulses;
        int        first;
        errs0    = errors;
        cur_test = "gpio_irq";
        mask     = (next_random() | 32'h1) & 32'h7fff_ffff;  // pin 31 stays masked
        pins     = next_random() | 32'h1;
        @(posedge clk);
        #1;
        gpio_in = '0;
        repeat (4) @(posedge clk);
        apb_write(reg_addr(GPIO_BASE_IDX, GPIO_INT_EN), mask);
        apb_read(reg_addr(GPIO_BASE_IDX, GPIO_INT_STATUS), rdata, err);
        check_data("status idle", '0, rdata);
        gpio_in = pins;
        watch_event_bit(GPIO_EVT_BIT, 8, pulses, first);
        check_data("irq pulses", 32'd1, apb_data_t'(pulses));
        if (first < 1 || first > 5) begin
            $display("ERROR %s: gpio event not seen within 5 cycles", cur_test);
            errors++;
        end
        apb_read(reg_addr(GPIO_BASE_IDX, GPIO_INT_STATUS), rdata, err);
        check_data("status", pins & mask, rdata);
        apb_read(reg_addr(GPIO_BASE_IDX, GPIO_INT_STATUS), rdata, err);
        check_data("status cleared", '0, rdata);
        // only masked-off pins rise now
        gpio_in = '0;
        repeat (4) @(posedge clk);
        #1;
        gpio_in = ~mask;
        watch_event_bit(GPIO_EVT_BIT, 8, pulses, first);
        check_data("masked pulses", '0, apb_data_t'(pulses));
        apb_read(reg_addr(GPIO_BASE_IDX, GPIO_INT_STATUS), rdata, err);
        check_data("masked status", '0, rdata);
        report_result(errs0);
    endtask

    task automatic sw_events();
        int        errs0;
        apb_data_t word;
        errs0    = errors;
        cur_test = "sw_events";
        word     = next_random();
        apb_write(reg_addr(EVT_BASE_IDX, EVT_SW), word);
        #1;
        check_events("pulse", {24'b0, word[7:0]}, fc_events);
        @(posedge clk);
        #2;
        check_events("after pulse", '0, fc_events);
        report_result(errs0);
    endtask

    task automatic ref_clock_edges();
        int        errs0;
        apb_data_t start;
        apb_data_t rdata;
        logic      err;
        int        pulses;
        int        first;
        errs0    = errors;
        cur_test = "ref_clock";
        apb_read(reg_addr(EVT_BASE_IDX, EVT_REF_CNT), start, err);
        for (int i = 0; i < REF_TOGGLES; i++) begin
            @(posedge clk);
            #1;
            slow_clk = ~slow_clk;
            watch_event_bit(REF_EDGE_EVT_BIT, 6, pulses, first);
            check_data("edge pulses", 32'd1, apb_data_t'(pulses));
        end
        apb_read(reg_addr(EVT_BASE_IDX, EVT_REF_CNT), rdata, err);
        check_data("edge count", (start + REF_TOGGLES) & 32'h0000_ffff, rdata);
        report_result(errs0);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        rst_n    = 1'b0;
        apb_req  = '0;
        gpio_in  = '0;
        slow_clk = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_values();
        soc_ctrl_rw();
        gpio_pins();
        gpio_interrupt();
        sw_events();
        ref_clock_edges();
        if (dut.u_asserts.fail_count != 0) begin
            $display("ERROR: %0d concurrent assertions failed", dut.u_asserts.fail_count);
            errors += dut.u_asserts.fail_count;
        end
        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("ERROR: watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/soc_periph_pkg.sv
hdl/apb_periph_decoder.sv
hdl/soc_ctrl_regs.sv
hdl/gpio_ctrl.sv
hdl/fc_event_map.sv
hdl/soc_peripherals.sv
sim/soc_periph_asserts.sv
sim/tb_soc_peripherals.sv
